// ==== nh_lcd.f ====
src/nh_lcd_pkg.sv
src/nh_lcd_command.sv
src/nh_lcd_timer.sv
src/nh_lcd_pixel.sv
src/nh_lcd_sequencer.sv
src/nh_lcd.sv
testbench/tb_nh_lcd.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
TOP       ?= tb_nh_lcd
FILELIST  ?= nh_lcd.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_nh_lcd.sv ====
`timescale 1ns/1ns

module tb_nh_lcd;

  import nh_lcd_pkg::*;

  typedef enum int {
    WATCH_RST_N,
    WATCH_WRITE,
    WATCH_READY,
    WATCH_PIXEL_READY,
    WATCH_FRAME_DONE,
    WATCH_REG_DONE
  } watch_t;

  logic         clk = 1'b0;
  logic         rst;
  logic         i_frame_stb;
  pixel_count_t i_pixel_count;
  logic         i_pixel_stb;
  pixel_t       i_pixel;
  logic         o_pixel_ready;
  logic         o_frame_done;
  logic         i_reg_read_stb;
  lcd_byte_t    i_reg_addr;
  lcd_byte_t    o_reg_data;
  logic         o_reg_done;
  logic         o_ready;
  logic         o_lcd_rst_n;
  logic         o_cmd_mode;
  logic         o_write;
  logic         o_read;
  lcd_byte_t    o_data_out;
  logic         o_data_out_en;
  lcd_byte_t    i_data_in;

  // Bus log and expected stream as {mode, byte} entries
  logic [8:0]   obs_q[$];
  logic [8:0]   exp_q[$];
  pixel_t       pixels[16];
  lcd_byte_t    last_cmd = 8'h00;
  int           frame_done_count = 0;
  int           frames_expected = 0;
  int           seed = 86;

  nh_lcd u_dut (
    .clk            (clk),
    .rst            (rst),
    .i_frame_stb    (i_frame_stb),
    .i_pixel_count  (i_pixel_count),
    .i_pixel_stb    (i_pixel_stb),
    .i_pixel        (i_pixel),
    .o_pixel_ready  (o_pixel_ready),
    .o_frame_done   (o_frame_done),
    .i_reg_read_stb (i_reg_read_stb),
    .i_reg_addr     (i_reg_addr),
    .o_reg_data     (o_reg_data),
    .o_reg_done     (o_reg_done),
    .o_ready        (o_ready),
    .o_lcd_rst_n    (o_lcd_rst_n),
    .o_cmd_mode     (o_cmd_mode),
    .o_write        (o_write),
    .o_read         (o_read),
    .o_data_out     (o_data_out),
    .o_data_out_en  (o_data_out_en),
    .i_data_in      (i_data_in)
  );

  always #20 clk = ~clk;

  // Panel register contents seen by a read
  function automatic lcd_byte_t panel_reg(input lcd_byte_t addr);
    return addr ^ 8'hA5;
  endfunction

  // Entry idx of a frame is the opcode, then high and low byte of each pixel
  function automatic logic [8:0] frame_byte(input int idx);
    pixel_t px;
    if (idx == 0) begin
      return {1'b0, CMD_MEMORY_WRITE};
    end
    px = pixels[(idx - 1) / 2];
    if (idx % 2 == 1) begin
      return {1'b1, px[15:8]};
    end
    return {1'b1, px[7:0]};
  endfunction

  function automatic logic watched(input watch_t sel);
    case (sel)
      WATCH_RST_N:       return o_lcd_rst_n;
      WATCH_WRITE:       return o_write;
      WATCH_READY:       return o_ready;
      WATCH_PIXEL_READY: return o_pixel_ready;
      WATCH_FRAME_DONE:  return o_frame_done;
      default:           return o_reg_done;
    endcase
  endfunction

  task automatic abort(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      abort($sformatf("error: t=%0t %s got %0h expected %0h", $time, name, got, want));
    end
  endtask

  // Counts low negedges before the signal is seen high
  task automatic wait_for(input watch_t sel, input string what, input int limit,
                          output int cycles);
    cycles = 0;
    @(negedge clk);
    while (watched(sel) !== 1'b1) begin
      if (cycles >= limit) begin
        abort($sformatf("timeout after %0d cycles waiting for %s", limit, what));
      end else begin
        cycles++;
        @(negedge clk);
      end
    end
  endtask

  task automatic drain_expected(input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (exp_q.size() != 0) begin
      if (cycles >= limit) begin
        abort("expected bus writes never appeared on the panel bus");
      end else begin
        cycles++;
        @(negedge clk);
      end
    end
  endtask

  task automatic run_frame(input int count, input logic gaps);
    int cycles;
    int gap;
    for (int k = 0; k < count; k++) begin
      pixels[k] = pixel_t'($random(seed));
    end
    for (int k = 0; k <= 2 * count; k++) begin
      exp_q.push_back(frame_byte(k));
    end
    frames_expected++;
    @(posedge clk);
    i_frame_stb   <= 1'b1;
    i_pixel_count <= pixel_count_t'(count);
    @(posedge clk);
    i_frame_stb <= 1'b0;
    for (int k = 0; k < count; k++) begin
      gap = gaps ? ($random(seed) & 15) : 0;
      repeat (gap) @(posedge clk);
      // Offer a pixel only while the serializer can take it
      wait_for(WATCH_PIXEL_READY, "o_pixel_ready", 100, cycles);
      @(posedge clk);
      i_pixel_stb <= 1'b1;
      i_pixel     <= pixels[k];
      @(posedge clk);
      i_pixel_stb <= 1'b0;
    end
    wait_for(WATCH_FRAME_DONE, "o_frame_done", 200, cycles);
    @(posedge clk);
    drain_expected(100);
    check("o_frame_done pulse count", frame_done_count, frames_expected);
  endtask

  task automatic read_register(input lcd_byte_t addr);
    int cycles;
    exp_q.push_back({1'b0, addr});
    @(posedge clk);
    i_reg_read_stb <= 1'b1;
    i_reg_addr     <= addr;
    @(posedge clk);
    i_reg_read_stb <= 1'b0;
    wait_for(WATCH_REG_DONE, "o_reg_done", 100, cycles);
    check("o_reg_data", 32'(o_reg_data), 32'(panel_reg(addr)));
    drain_expected(100);
    wait_for(WATCH_READY, "o_ready", 100, cycles);
  endtask

  // Panel answers a read with the register of the last command byte
  assign i_data_in = (o_read === 1'b1) ? panel_reg(last_cmd) : 8'h00;

  // Bus monitor
  always @(negedge clk) begin
    if (rst === 1'b0) begin
      if (o_write === 1'b1) begin
        obs_q.push_back({o_cmd_mode, o_data_out});
        if (o_cmd_mode === 1'b0) begin
          last_cmd = o_data_out;
        end
      end
      if (o_read === 1'b1) begin
        check("o_data_out_en", 32'(o_data_out_en), 0);
      end
      if (o_ready === 1'b1) begin
        check("o_pixel_ready", 32'(o_pixel_ready), 0);
      end
      if (o_frame_done === 1'b1) begin
        frame_done_count++;
      end
    end
  end

  // Comparison of logged writes against the expected stream
  always @(posedge clk) begin
    logic [8:0] seen;
    while (obs_q.size() != 0) begin
      seen = obs_q.pop_front();
      if (exp_q.size() == 0) begin
        abort($sformatf("unexpected bus write of %0h with mode %0b", seen[7:0], seen[8]));
      end else begin
        check("o_cmd_mode,o_data_out", 32'(seen), 32'(exp_q.pop_front()));
      end
    end
  end

  initial begin
    #2000000;
    abort("simulation did not finish in time");
  end

  initial begin
    int cycles;
    rst            = 1'b1;
    i_frame_stb    = 1'b0;
    i_pixel_count  = '0;
    i_pixel_stb    = 1'b0;
    i_pixel        = '0;
    i_reg_read_stb = 1'b0;
    i_reg_addr     = '0;
    exp_q.push_back({1'b0, CMD_SLEEP_OUT});
    exp_q.push_back({1'b0, CMD_DISPLAY_ON});
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    check("o_write", 32'(o_write), 0);
    check("o_read", 32'(o_read), 0);
    check("o_data_out_en", 32'(o_data_out_en), 0);
    check("o_ready", 32'(o_ready), 0);
    check("o_pixel_ready", 32'(o_pixel_ready), 0);
    check("o_lcd_rst_n", 32'(o_lcd_rst_n), 0);

    // Power-up pacing
    wait_for(WATCH_RST_N, "o_lcd_rst_n", 200, cycles);
    if (cycles < int'(RESET_HOLD_CYCLES)) begin
      abort($sformatf("error: t=%0t o_lcd_rst_n low for %0d cycles, expected at least %0d",
                      $time, cycles, RESET_HOLD_CYCLES));
    end
    wait_for(WATCH_WRITE, "sleep-out write", 500, cycles);
    if (cycles < int'(WAKE_CYCLES)) begin
      abort($sformatf("error: t=%0t o_write gap %0d cycles, expected at least %0d",
                      $time, cycles, WAKE_CYCLES));
    end
    wait_for(WATCH_WRITE, "display-on write", 500, cycles);
    if (cycles < int'(WAKE_CYCLES)) begin
      abort($sformatf("error: t=%0t o_write gap %0d cycles, expected at least %0d",
                      $time, cycles, WAKE_CYCLES));
    end
    wait_for(WATCH_READY, "o_ready", 100, cycles);

    run_frame(8, 1'b0);
    run_frame(8, 1'b1);
    run_frame(0, 1'b0);
    repeat (4) begin
      read_register(lcd_byte_t'($random(seed)));
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== src/nh_lcd.sv ====
`timescale 1ns/1ns

module nh_lcd (
  input  logic                     clk,
  input  logic                     rst,

  // Host frame interface
  input  logic                     i_frame_stb,
  input  nh_lcd_pkg::pixel_count_t i_pixel_count,
  input  logic                     i_pixel_stb,
  input  nh_lcd_pkg::pixel_t       i_pixel,
  output logic                     o_pixel_ready,
  output logic                     o_frame_done,

  // Host register read
  input  logic                     i_reg_read_stb,
  input  nh_lcd_pkg::lcd_byte_t    i_reg_addr,
  output nh_lcd_pkg::lcd_byte_t    o_reg_data,
  output logic                     o_reg_done,
  output logic                     o_ready,

  // Panel bus
  output logic                     o_lcd_rst_n,
  output logic                     o_cmd_mode,
  output logic                     o_write,
  output logic                     o_read,
  output nh_lcd_pkg::lcd_byte_t    o_data_out,
  output logic                     o_data_out_en,
  input  nh_lcd_pkg::lcd_byte_t    i_data_in
);

  import nh_lcd_pkg::*;

  logic      timer_start;
  delay_t    timer_cycles;
  logic      timer_done;
  logic      cmd_write_stb;
  logic      cmd_read_stb;
  logic      cmd_parameter;
  lcd_byte_t cmd_data;
  logic      cmd_finished;
  logic      byte_valid;
  lcd_byte_t pixel_byte;
  logic      byte_taken;
  logic      accept_pixels;

  nh_lcd_sequencer u_sequencer (
    .clk             (clk),
    .rst             (rst),
    .i_frame_stb     (i_frame_stb),
    .i_pixel_count   (i_pixel_count),
    .i_reg_read_stb  (i_reg_read_stb),
    .i_reg_addr      (i_reg_addr),
    .i_timer_done    (timer_done),
    .o_timer_start   (timer_start),
    .o_timer_cycles  (timer_cycles),
    .i_cmd_finished  (cmd_finished),
    .o_cmd_write_stb (cmd_write_stb),
    .o_cmd_read_stb  (cmd_read_stb),
    .o_cmd_parameter (cmd_parameter),
    .o_cmd_data      (cmd_data),
    .i_byte_valid    (byte_valid),
    .i_pixel_byte    (pixel_byte),
    .o_byte_taken    (byte_taken),
    .o_accept_pixels (accept_pixels),
    .o_lcd_rst_n     (o_lcd_rst_n),
    .o_ready         (o_ready),
    .o_frame_done    (o_frame_done),
    .o_reg_done      (o_reg_done)
  );

  nh_lcd_timer u_timer (
    .clk      (clk),
    .rst      (rst),
    .i_start  (timer_start),
    .i_cycles (timer_cycles),
    .o_done   (timer_done)
  );

  nh_lcd_pixel u_pixel (
    .clk           (clk),
    .rst           (rst),
    .i_pixel_stb   (i_pixel_stb),
    .i_pixel       (i_pixel),
    .o_pixel_ready (o_pixel_ready),
    .i_accept      (accept_pixels),
    .i_byte_taken  (byte_taken),
    .o_byte_valid  (byte_valid),
    .o_byte        (pixel_byte)
  );

  nh_lcd_command u_command (
    .clk             (clk),
    .rst             (rst),
    .i_cmd_write_stb (cmd_write_stb),
    .i_cmd_read_stb  (cmd_read_stb),
    .i_cmd_parameter (cmd_parameter),
    .i_cmd_data      (cmd_data),
    .o_cmd_data      (o_reg_data),
    .o_cmd_finished  (cmd_finished),
    .o_cmd_mode      (o_cmd_mode),
    .o_write         (o_write),
    .o_read          (o_read),
    .o_data_out_en   (o_data_out_en),
    .o_data_out      (o_data_out),
    .i_data_in       (i_data_in)
  );

endmodule

// ==== src/nh_lcd_sequencer.sv ====
`timescale 1ns/1ns

module nh_lcd_sequencer (
  input  logic                     clk,
  input  logic                     rst,

  // Host requests
  input  logic                     i_frame_stb,
  input  nh_lcd_pkg::pixel_count_t i_pixel_count,
  input  logic                     i_reg_read_stb,
  input  nh_lcd_pkg::lcd_byte_t    i_reg_addr,

  // Timer
  input  logic                     i_timer_done,
  output logic                     o_timer_start,
  output nh_lcd_pkg::delay_t       o_timer_cycles,

  // Bus engine
  input  logic                     i_cmd_finished,
  output logic                     o_cmd_write_stb,
  output logic                     o_cmd_read_stb,
  output logic                     o_cmd_parameter,
  output nh_lcd_pkg::lcd_byte_t    o_cmd_data,

  // Pixel serializer
  input  logic                     i_byte_valid,
  input  nh_lcd_pkg::lcd_byte_t    i_pixel_byte,
  output logic                     o_byte_taken,
  output logic                     o_accept_pixels,

  // Status
  output logic                     o_lcd_rst_n,
  output logic                     o_ready,
  output logic                     o_frame_done,
  output logic                     o_reg_done
);

  import nh_lcd_pkg::*;

  seq_state_t   state;
  // Set while a timer wait or bus transfer is outstanding
  logic         pending;
  // Pixels whose high byte has not been sent yet
  pixel_count_t pixels_left;
  lcd_byte_t    reg_addr;
  logic         in_frame;

  assign in_frame        = (state == FRAME_CMD) || (state == PIXEL_HI) || (state == PIXEL_LO);
  assign o_accept_pixels = in_frame && (pixels_left != '0);
  assign o_ready         = (state == READY);
  assign o_cmd_parameter = (state == PIXEL_HI) || (state == PIXEL_LO) || (state == REG_READ);

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= RESET_HOLD;
      pending         <= 1'b0;
      o_lcd_rst_n     <= 1'b0;
      o_timer_start   <= 1'b0;
      o_cmd_write_stb <= 1'b0;
      o_cmd_read_stb  <= 1'b0;
      o_byte_taken    <= 1'b0;
      o_frame_done    <= 1'b0;
      o_reg_done      <= 1'b0;
    end else begin
      o_timer_start   <= 1'b0;
      o_cmd_write_stb <= 1'b0;
      o_cmd_read_stb  <= 1'b0;
      o_byte_taken    <= 1'b0;
      o_frame_done    <= 1'b0;
      o_reg_done      <= 1'b0;
      case (state)
        RESET_HOLD, RESET_WAIT, WAKE_WAIT: begin
          if (!pending) begin
            o_timer_start <= 1'b1;
            pending       <= 1'b1;
          end else if (i_timer_done) begin
            pending <= 1'b0;
            if (state == RESET_HOLD) begin
              // Release the panel, then let it settle
              o_lcd_rst_n <= 1'b1;
              state       <= RESET_WAIT;
            end else if (state == RESET_WAIT) begin
              state <= SLEEP_OUT;
            end else begin
              state <= DISPLAY_ON;
            end
          end
        end
        SLEEP_OUT, DISPLAY_ON, FRAME_CMD, REG_CMD: begin
          if (!pending) begin
            o_cmd_write_stb <= 1'b1;
            pending         <= 1'b1;
          end else if (i_cmd_finished) begin
            pending <= 1'b0;
            case (state)
              SLEEP_OUT:  state <= WAKE_WAIT;
              DISPLAY_ON: state <= READY;
              REG_CMD:    state <= REG_READ;
              default: begin
                // Empty frame ends right after the opcode
                if (pixels_left == '0) begin
                  o_frame_done <= 1'b1;
                  state        <= READY;
                end else begin
                  state <= PIXEL_HI;
                end
              end
            endcase
          end
        end
        READY: begin
          if (i_frame_stb) begin
            state <= FRAME_CMD;
          end else if (i_reg_read_stb) begin
            state <= REG_CMD;
          end
        end
        PIXEL_HI, PIXEL_LO: begin
          if (!pending) begin
            if (i_byte_valid) begin
              o_cmd_write_stb <= 1'b1;
              o_byte_taken    <= 1'b1;
              pending         <= 1'b1;
            end
          end else if (i_cmd_finished) begin
            pending <= 1'b0;
            if (state == PIXEL_HI) begin
              state <= PIXEL_LO;
            end else if (pixels_left == '0) begin
              o_frame_done <= 1'b1;
              state        <= READY;
            end else begin
              state <= PIXEL_HI;
            end
          end
        end
        default: begin
          // Register read cycle
          if (!pending) begin
            o_cmd_read_stb <= 1'b1;
            pending        <= 1'b1;
          end else if (i_cmd_finished) begin
            pending    <= 1'b0;
            o_reg_done <= 1'b1;
            state      <= READY;
          end
        end
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (state == READY && i_frame_stb) begin
      pixels_left <= i_pixel_count;
    end else if (state == PIXEL_HI && !pending && i_byte_valid) begin
      pixels_left <= pixels_left - pixel_count_t'(1);
    end
    if (state == READY && i_reg_read_stb) begin
      reg_addr <= i_reg_addr;
    end
    o_timer_cycles <= (state == RESET_HOLD) ? RESET_HOLD_CYCLES : WAKE_CYCLES;
    case (state)
      SLEEP_OUT:  o_cmd_data <= CMD_SLEEP_OUT;
      DISPLAY_ON: o_cmd_data <= CMD_DISPLAY_ON;
      FRAME_CMD:  o_cmd_data <= CMD_MEMORY_WRITE;
      REG_CMD:    o_cmd_data <= reg_addr;
      default:    o_cmd_data <= i_pixel_byte;
    endcase
  end

endmodule

// ==== src/nh_lcd_pixel.sv ====
`timescale 1ns/1ns

module nh_lcd_pixel (
  input  logic                  clk,
  input  logic                  rst,

  // Host side
  input  logic                  i_pixel_stb,
  input  nh_lcd_pkg::pixel_t    i_pixel,
  output logic                  o_pixel_ready,

  // Sequencer side
  input  logic                  i_accept,
  input  logic                  i_byte_taken,
  output logic                  o_byte_valid,
  output nh_lcd_pkg::lcd_byte_t o_byte
);

  import nh_lcd_pkg::*;

  pixel_t pixel_q;
  logic   low_half;
  logic   load;

  assign o_pixel_ready = !o_byte_valid && i_accept;
  assign load          = i_pixel_stb && o_pixel_ready;

  // High byte goes out first
  assign o_byte = low_half ? pixel_q[7:0] : pixel_q[15:8];

  always_ff @(posedge clk) begin
    if (rst) begin
      o_byte_valid <= 1'b0;
      low_half     <= 1'b0;
    end else if (load) begin
      o_byte_valid <= 1'b1;
      low_half     <= 1'b0;
    end else if (i_byte_taken && o_byte_valid) begin
      if (low_half) begin
        // Both halves gone, slot is free again
        o_byte_valid <= 1'b0;
        low_half     <= 1'b0;
      end else begin
        low_half <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      pixel_q <= i_pixel;
    end
  end

endmodule

// ==== src/nh_lcd_timer.sv ====
`timescale 1ns/1ns

module nh_lcd_timer (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_start,
  input  nh_lcd_pkg::delay_t i_cycles,
  output logic               o_done
);

  import nh_lcd_pkg::*;

  delay_t count;
  logic   busy;

  // Done in the cycle the count reaches zero
  assign o_done = busy && (count == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (i_start) begin
      busy <= 1'b1;
    end else if (o_done) begin
      busy <= 1'b0;
    end
  end

  // Loaded one short so done lands i_cycles after the start
  always_ff @(posedge clk) begin
    if (i_start) begin
      count <= i_cycles - delay_t'(1);
    end else if (busy && count != '0) begin
      count <= count - delay_t'(1);
    end
  end

endmodule

// ==== src/nh_lcd_command.sv ====
`timescale 1ns/1ns

module nh_lcd_command (
  input  logic                  clk,
  input  logic                  rst,

  // Transfer request from the sequencer
  input  logic                  i_cmd_write_stb,
  input  logic                  i_cmd_read_stb,
  input  logic                  i_cmd_parameter,
  input  nh_lcd_pkg::lcd_byte_t i_cmd_data,
  output nh_lcd_pkg::lcd_byte_t o_cmd_data,
  output logic                  o_cmd_finished,

  // Panel bus
  output logic                  o_cmd_mode,
  output logic                  o_write,
  output logic                  o_read,
  output logic                  o_data_out_en,
  output nh_lcd_pkg::lcd_byte_t o_data_out,
  input  nh_lcd_pkg::lcd_byte_t i_data_in
);

  typedef enum logic [1:0] {
    IDLE,
    READ_WAIT,
    FINISHED
  } cmd_state_t;

  cmd_state_t state;

  // Low selects a command byte, high a parameter or data byte
  assign o_cmd_mode = i_cmd_parameter;

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= IDLE;
      o_write        <= 1'b0;
      o_read         <= 1'b0;
      o_data_out_en  <= 1'b0;
      o_cmd_finished <= 1'b0;
    end else begin
      o_cmd_finished <= 1'b0;
      case (state)
        IDLE: begin
          o_write       <= 1'b0;
          o_read        <= 1'b0;
          o_data_out_en <= 1'b0;
          if (i_cmd_write_stb) begin
            // Drive the byte and strobe it out
            o_data_out_en <= 1'b1;
            o_write       <= 1'b1;
            state         <= FINISHED;
          end else if (i_cmd_read_stb) begin
            // Bus stays released while the panel drives it
            o_read <= 1'b1;
            state  <= READ_WAIT;
          end
        end
        READ_WAIT: begin
          state <= FINISHED;
        end
        default: begin
          o_write        <= 1'b0;
          o_read         <= 1'b0;
          o_cmd_finished <= 1'b1;
          state          <= IDLE;
        end
      endcase
    end
  end

  // Write byte and read capture
  always_ff @(posedge clk) begin
    if (state == IDLE && i_cmd_write_stb) begin
      o_data_out <= i_cmd_data;
    end
    if (state == FINISHED && !o_data_out_en) begin
      o_cmd_data <= i_data_in;
    end
  end

endmodule

// ==== src/nh_lcd_pkg.sv ====
package nh_lcd_pkg;

  // Bus and pixel widths
  typedef logic [7:0]  lcd_byte_t;
  typedef logic [15:0] pixel_t;
  typedef logic [15:0] pixel_count_t;
  typedef logic [15:0] delay_t;

  // Panel opcodes
  localparam lcd_byte_t CMD_SLEEP_OUT    = 8'h11;
  localparam lcd_byte_t CMD_DISPLAY_ON   = 8'h29;
  localparam lcd_byte_t CMD_MEMORY_WRITE = 8'h2C;

  // Power-up waits, shortened for simulation
  localparam delay_t RESET_HOLD_CYCLES = 16'd20;
  localparam delay_t WAKE_CYCLES       = 16'd50;

  // Sequencer states
  typedef enum logic [3:0] {
    RESET_HOLD,
    RESET_WAIT,
    SLEEP_OUT,
    WAKE_WAIT,
    DISPLAY_ON,
    READY,
    FRAME_CMD,
    PIXEL_HI,
    PIXEL_LO,
    REG_CMD,
    REG_READ
  } seq_state_t;

endpackage
